//--- verilog/link_pkg.sv
package link_pkg;

   // Packet layout, lsb first on the lane
   localparam int PW          = 104;               // Full packet width
   localparam int LANE_W      = 8;                 // Byte lane
   localparam int NBYTES      = PW / LANE_W;       // 13 beats per packet

   // Control byte
   localparam int CTRL_LSB    = 0;                 // Control byte at 7..0
   localparam int WRITE_BIT   = 1;                 // Write request
   localparam int RESP_BIT    = 2;                 // Read response

   // Address and data fields
   localparam int AW          = 32;                // Address width
   localparam int DW          = 32;                // Data width
   localparam int DST_LSB     = 8;                 // Destination 39..8
   localparam int DATA_LSB    = 40;                // Data 71..40
   localparam int SRC_LSB     = 72;                // Source 103..72

   // Register memory
   localparam int MEM_AW      = 6;                 // Word index width
   localparam int MEM_WORDS   = 1 << MEM_AW;       // 64 words
   localparam int MEM_IDX_LSB = DST_LSB + 2;       // Word aligned, dst bits 7..2

   // Beat counters
   localparam int CNT_W       = 4;                 // Counts 0..NBYTES-1

endpackage

//--- verilog/link_tx.sv
`timescale 1ns/1ns

module link_tx (
   input  logic                          clkin,
   input  logic                          reset,
   input  logic                          txrd_access,
   input  logic [link_pkg::PW-1:0]       txrd_packet,
   input  logic                          txwr_access,
   input  logic [link_pkg::PW-1:0]       txwr_packet,
   input  logic                          txrr_access,
   input  logic [link_pkg::PW-1:0]       txrr_packet,
   output logic                          txrd_wait,
   output logic                          txwr_wait,
   output logic                          txrr_wait,
   output logic                          lane_frame,
   output logic [link_pkg::LANE_W-1:0]   lane_data
);

   logic [link_pkg::PW-1:0]    shift_q;        // Bytes still to send
   logic [link_pkg::CNT_W-1:0] cnt_q;          // Beats left after current one
   logic                       busy_q;         // Packet on the lane
   logic                       grant_rr;
   logic                       grant_rd;
   logic                       grant_wr;
   logic                       grant_any;
   logic [link_pkg::PW-1:0]    grant_pkt;      // Packet of winning channel

   // Waits are levels, response channel blocks external traffic
   assign txrr_wait  = busy_q;
   assign txrd_wait  = busy_q | txrr_access;
   assign txwr_wait  = busy_q | txrr_access | txrd_access; // Read beats write

   // Fixed priority rr > rd > wr
   assign grant_rr   = txrr_access & ~txrr_wait;
   assign grant_rd   = txrd_access & ~txrd_wait;
   assign grant_wr   = txwr_access & ~txwr_wait;
   assign grant_any  = grant_rr | grant_rd | grant_wr;

   always_comb begin
      if (txrr_access) begin
         grant_pkt = txrr_packet;              // Response first
      end else if (txrd_access) begin
         grant_pkt = txrd_packet;
      end else begin
         grant_pkt = txwr_packet;
      end
   end

   assign lane_frame = busy_q;                 // Frame tracks busy exactly

   // Control, accept at T, frame T+1..T+13, idle again at T+14
   always_ff @(posedge clkin or posedge reset) begin
      if (reset) begin
         busy_q <= 1'b0;
         cnt_q  <= '0;
      end else if (!busy_q) begin
         if (grant_any) begin
            busy_q <= 1'b1;                    // First beat goes out now
            cnt_q  <= link_pkg::CNT_W'(link_pkg::NBYTES - 1);
         end
      end else if (cnt_q == '0) begin
         busy_q <= 1'b0;                       // Last beat was on the lane
      end else begin
         cnt_q  <= cnt_q - 1'b1;
      end
   end

   // Serializer, lsb byte first so control byte leads
   always_ff @(posedge clkin) begin
      if (!busy_q && grant_any) begin
         lane_data <= grant_pkt[link_pkg::LANE_W-1:0];
         shift_q   <= grant_pkt >> link_pkg::LANE_W;
      end else if (busy_q) begin
         lane_data <= shift_q[link_pkg::LANE_W-1:0];
         shift_q   <= shift_q >> link_pkg::LANE_W; // Next byte down
      end
   end

endmodule

//--- verilog/link_rx.sv
`timescale 1ns/1ns

module link_rx (
   input  logic                          clkin,
   input  logic                          reset,
   input  logic                          lane_frame,
   input  logic [link_pkg::LANE_W-1:0]   lane_data,
   output logic                          rxrd_access,
   output logic [link_pkg::PW-1:0]       rxrd_packet,
   output logic                          rxwr_access,
   output logic [link_pkg::PW-1:0]       rxwr_packet,
   output logic                          rxrr_access,
   output logic [link_pkg::PW-1:0]       rxrr_packet
);

   logic [link_pkg::PW-1:0]    pkt_q;          // Assembly register
   logic [link_pkg::PW-1:0]    pkt_next;       // Packet with this beat in
   logic [link_pkg::CNT_W-1:0] cnt_q;          // Beats seen so far
   logic                       last_beat;
   logic                       is_resp;
   logic                       is_write;

   // New byte enters at the top, earlier bytes move down
   assign pkt_next  = {lane_data, pkt_q[link_pkg::PW-1:link_pkg::LANE_W]};
   assign last_beat = lane_frame & (cnt_q == link_pkg::CNT_W'(link_pkg::NBYTES - 1));

   // Control byte is fully aligned once the last beat is in
   assign is_resp   = pkt_next[link_pkg::CTRL_LSB + link_pkg::RESP_BIT];
   assign is_write  = pkt_next[link_pkg::CTRL_LSB + link_pkg::WRITE_BIT];

   always_ff @(posedge clkin or posedge reset) begin
      if (reset) begin
         cnt_q       <= '0;
         rxrd_access <= 1'b0;
         rxwr_access <= 1'b0;
         rxrr_access <= 1'b0;
      end else begin
         if (!lane_frame || last_beat) begin
            cnt_q <= '0;                       // Realign on every frame
         end else begin
            cnt_q <= cnt_q + 1'b1;
         end
         // One pulse per packet, response wins over write
         rxrr_access <= last_beat & is_resp;
         rxwr_access <= last_beat & ~is_resp & is_write;
         rxrd_access <= last_beat & ~is_resp & ~is_write;
      end
   end

   always_ff @(posedge clkin) begin
      if (lane_frame) begin
         pkt_q <= pkt_next;                    // Shift in framed byte
      end
   end

   // Same register feeds all channels, only the pulse differs
   assign rxrd_packet = pkt_q;
   assign rxwr_packet = pkt_q;
   assign rxrr_packet = pkt_q;

endmodule

//--- verilog/link_mem.sv
`timescale 1ns/1ns

module link_mem (
   input  logic                          clkin,
   input  logic                          reset,
   input  logic                          rd_access,
   input  logic [link_pkg::PW-1:0]       rd_packet,
   input  logic                          wr_access,
   input  logic [link_pkg::PW-1:0]       wr_packet,
   input  logic                          rr_wait,
   output logic                          rr_access,
   output logic [link_pkg::PW-1:0]       rr_packet
);

   logic [link_pkg::DW-1:0]     mem_q [link_pkg::MEM_WORDS];
   logic [link_pkg::MEM_AW-1:0] wr_idx;        // Word index of write
   logic [link_pkg::MEM_AW-1:0] rd_idx;        // Word index of read
   logic [link_pkg::PW-1:0]     resp_pkt;      // Response being built

   assign wr_idx = wr_packet[link_pkg::MEM_IDX_LSB +: link_pkg::MEM_AW];
   assign rd_idx = rd_packet[link_pkg::MEM_IDX_LSB +: link_pkg::MEM_AW];

   // Response, addresses swapped, only resp bit set in control
   always_comb begin
      resp_pkt = '0;
      resp_pkt[link_pkg::CTRL_LSB + link_pkg::RESP_BIT] = 1'b1;
      resp_pkt[link_pkg::DST_LSB +: link_pkg::AW] =
         rd_packet[link_pkg::SRC_LSB +: link_pkg::AW];    // Back to requester
      resp_pkt[link_pkg::DATA_LSB +: link_pkg::DW] = mem_q[rd_idx];
      resp_pkt[link_pkg::SRC_LSB +: link_pkg::AW] =
         rd_packet[link_pkg::DST_LSB +: link_pkg::AW];    // From read target
   end

   // Storage and response valid
   always_ff @(posedge clkin or posedge reset) begin
      if (reset) begin
         for (int i = 0; i < link_pkg::MEM_WORDS; i++) begin
            mem_q[i] <= '0;                    // Memory starts all zero
         end
         rr_access <= 1'b0;
      end else begin
         if (wr_access) begin
            mem_q[wr_idx] <= wr_packet[link_pkg::DATA_LSB +: link_pkg::DW];
         end
         if (rd_access) begin
            rr_access <= 1'b1;                 // Valid from next cycle
         end else if (!rr_wait) begin
            rr_access <= 1'b0;                 // Taken by transmitter
         end
      end
   end

   // Response payload, held while pending
   always_ff @(posedge clkin) begin
      if (rd_access) begin
         rr_packet <= resp_pkt;
      end
   end

endmodule

//--- verilog/link_loopback_top.sv
`timescale 1ns/1ns

module link_loopback_top (
   input  logic                          clkin,
   input  logic                          reset,
   input  logic                          ext_access,
   input  logic [link_pkg::PW-1:0]       ext_packet,
   output logic                          dut_rd_wait,
   output logic                          dut_wr_wait,
   output logic                          dut_access,
   output logic [link_pkg::PW-1:0]       dut_packet
);

   logic                        txrd_access;
   logic                        txwr_access;
   logic                        txrd_wait;
   logic                        txwr_wait;
   logic                        txrr_access;   // Memory response
   logic [link_pkg::PW-1:0]     txrr_packet;
   logic                        txrr_wait;
   logic                        lane_frame;    // Looped lane
   logic [link_pkg::LANE_W-1:0] lane_data;
   logic                        rxrd_access;
   logic [link_pkg::PW-1:0]     rxrd_packet;
   logic                        rxwr_access;
   logic [link_pkg::PW-1:0]     rxwr_packet;
   logic                        rxrr_access;
   logic [link_pkg::PW-1:0]     rxrr_packet;

   // Split external traffic on the write bit
   assign txwr_access = ext_access &  ext_packet[link_pkg::CTRL_LSB + link_pkg::WRITE_BIT];
   assign txrd_access = ext_access & ~ext_packet[link_pkg::CTRL_LSB + link_pkg::WRITE_BIT];
   assign dut_rd_wait = txrd_wait;             // Pushback to source
   assign dut_wr_wait = txwr_wait;

   link_tx i_link_tx (
      .clkin       (clkin),
      .reset       (reset),
      .txrd_access (txrd_access),
      .txrd_packet (ext_packet),               // Same packet on both paths
      .txwr_access (txwr_access),
      .txwr_packet (ext_packet),
      .txrr_access (txrr_access),
      .txrr_packet (txrr_packet),
      .txrd_wait   (txrd_wait),
      .txwr_wait   (txwr_wait),
      .txrr_wait   (txrr_wait),
      .lane_frame  (lane_frame),
      .lane_data   (lane_data)
   );

   link_rx i_link_rx (
      .clkin       (clkin),
      .reset       (reset),
      .lane_frame  (lane_frame),               // Straight loopback
      .lane_data   (lane_data),
      .rxrd_access (rxrd_access),
      .rxrd_packet (rxrd_packet),
      .rxwr_access (rxwr_access),
      .rxwr_packet (rxwr_packet),
      .rxrr_access (rxrr_access),
      .rxrr_packet (rxrr_packet)
   );

   link_mem i_link_mem (
      .clkin       (clkin),
      .reset       (reset),
      .rd_access   (rxrd_access),
      .rd_packet   (rxrd_packet),
      .wr_access   (rxwr_access),
      .wr_packet   (rxwr_packet),
      .rr_wait     (txrr_wait),
      .rr_access   (txrr_access),
      .rr_packet   (txrr_packet)
   );

   // Responses leave without back-pressure
   assign dut_access = rxrr_access;
   assign dut_packet = rxrr_packet;

endmodule

//--- verification/link_loopback_tb.sv
`timescale 1ns/1ns

module link_loopback_tb;

   localparam int N_TRANS     = 2 + 1 + 40 + 16 + 30;    // Requests over all tests
   localparam int CYCLE_LIMIT = N_TRANS * 32 + 200;
   localparam int IDX_LSB     = link_pkg::DST_LSB + 2;   // Word index from dst bits 7..2

   logic                    clkin;
   logic                    reset;
   logic                    ext_access;
   logic [link_pkg::PW-1:0] ext_packet;
   logic                    dut_rd_wait;
   logic                    dut_wr_wait;
   logic                    dut_access;
   logic [link_pkg::PW-1:0] dut_packet;

   logic [link_pkg::DW-1:0] shadow [link_pkg::MEM_WORDS]; // Reference memory
   logic [link_pkg::PW-1:0] exp_q [$];                    // Expected in request order
   logic [31:0]             lfsr_q;
   int                      errors;
   int                      checks;
   int                      tests;
   int                      failed_tests;
   int                      resp_count;                    // Responses seen
   int                      reads_sent;                    // Reads accepted
   int                      both_wait_cycles;              // Both waits high
   int                      cycle_cnt;

   link_loopback_top i_link_loopback_top (
      .clkin       (clkin),
      .reset       (reset),
      .ext_access  (ext_access),
      .ext_packet  (ext_packet),
      .dut_rd_wait (dut_rd_wait),
      .dut_wr_wait (dut_wr_wait),
      .dut_access  (dut_access),
      .dut_packet  (dut_packet)
   );

   initial begin
      clkin = 1'b0;
      forever #2 clkin = ~clkin;                // 4 ns period
   end

   // Galois LFSR for x^32+x^22+x^2+x+1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   // One step per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] val;
      val = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_q = lfsr_step(lfsr_q);
         val    = {val[30:0], lfsr_q[0]};
      end
      return val;
   endfunction

   function automatic logic [link_pkg::PW-1:0] make_req(input logic is_wr,
      input logic [31:0] dst, input logic [31:0] data, input logic [31:0] src);
      logic [link_pkg::PW-1:0] pkt;
      pkt = '0;
      pkt[link_pkg::CTRL_LSB + link_pkg::WRITE_BIT] = is_wr;
      pkt[link_pkg::DST_LSB +: 32]  = dst;
      pkt[link_pkg::DATA_LSB +: 32] = data;
      pkt[link_pkg::SRC_LSB +: 32]  = src;
      return pkt;
   endfunction

   // Expected answer with swapped addresses and only the response bit set
   function automatic logic [link_pkg::PW-1:0] expected_response(
      input logic [link_pkg::PW-1:0] req);
      logic [link_pkg::PW-1:0] rsp;
      rsp = '0;
      rsp[link_pkg::CTRL_LSB + link_pkg::RESP_BIT] = 1'b1;
      rsp[link_pkg::DST_LSB +: 32]  = req[link_pkg::SRC_LSB +: 32];
      rsp[link_pkg::DATA_LSB +: 32] = shadow[req[IDX_LSB +: link_pkg::MEM_AW]];
      rsp[link_pkg::SRC_LSB +: 32]  = req[link_pkg::DST_LSB +: 32];
      return rsp;
   endfunction

   task automatic check_value(input logic [link_pkg::PW-1:0] got,
      input logic [link_pkg::PW-1:0] exp, input string msg);
      checks++;
      if (got !== exp) begin
         $display("CHECK FAILED at %0t: %s, got %h expected %h", $time, msg, got, exp);
         errors++;
      end
   endtask

   // Called at a rising edge and returns at the accepting edge
   task automatic send(input logic [link_pkg::PW-1:0] pkt);
      logic is_wr;
      logic taken;
      is_wr = pkt[link_pkg::CTRL_LSB + link_pkg::WRITE_BIT];
      taken = 1'b0;
      ext_access <= 1'b1;
      ext_packet <= pkt;
      while (!taken) begin
         @(negedge clkin);
         taken = is_wr ? !dut_wr_wait : !dut_rd_wait;   // Next edge takes it
         if (taken && is_wr) begin
            shadow[pkt[IDX_LSB +: link_pkg::MEM_AW]] = pkt[link_pkg::DATA_LSB +: 32];
         end else if (taken) begin
            exp_q.push_back(expected_response(pkt));    // Memory as of now
            reads_sent++;
         end
         @(posedge clkin);
      end
   endtask

   // Wait a bounded time for outstanding responses
   task automatic drain();
      int n;
      ext_access <= 1'b0;
      n = 0;
      while (exp_q.size() != 0 && n < 80) begin
         @(posedge clkin);
         n++;
      end
      repeat (4) @(posedge clkin);
      if (exp_q.size() != 0) begin
         $display("Responses missing: %0d reads still unanswered at %0t",
                  exp_q.size(), $time);
         errors++;
         exp_q.delete();
      end
   endtask

   task automatic report_test(input string name, input int errs_before);
      tests++;
      if (errors != errs_before) begin
         failed_tests++;
         $display("test %s: failed with %0d errors", name, errors - errs_before);
      end else begin
         $display("test %s: ok", name);
      end
   endtask

   // Response checker samples mid-cycle
   always @(negedge clkin) begin
      if (!reset && dut_access) begin
         resp_count++;
         if (exp_q.size() == 0) begin
            $display("Unexpected response at %0t with no read outstanding", $time);
            errors++;
         end else begin
            check_value(dut_packet, exp_q.pop_front(), "read response");
         end
      end
      if (!reset && dut_rd_wait && dut_wr_wait) begin
         both_wait_cycles++;
      end
   end

   initial begin
      cycle_cnt = 0;
      while (cycle_cnt < CYCLE_LIMIT) begin
         @(posedge clkin);
         cycle_cnt++;
      end
      $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("SOME TESTS FAILED");
      $finish;
   end

   initial begin
      logic [31:0] addr [20];
      logic [31:0] dst;
      logic [31:0] data;
      logic [31:0] src;
      logic        is_wr;
      int          e0;
      int          r0;
      int          q0;
      reset        = 1'b1;
      ext_access   = 1'b0;
      ext_packet   = '0;
      lfsr_q       = 32'd51;                    // Seed
      errors       = 0;
      checks       = 0;
      tests        = 0;
      failed_tests = 0;
      resp_count   = 0;
      reads_sent   = 0;
      both_wait_cycles = 0;
      for (int i = 0; i < link_pkg::MEM_WORDS; i++) begin
         shadow[i] = '0;
      end
      repeat (8) @(posedge clkin);
      reset <= 1'b0;

      e0 = errors;                              // Idle after reset
      repeat (10) begin
         @(negedge clkin);
         check_value(dut_rd_wait, 1'b0, "rd wait idle");
         check_value(dut_wr_wait, 1'b0, "wr wait idle");
         check_value(dut_access, 1'b0, "access idle");
      end
      @(posedge clkin);
      report_test("reset_idle", e0);

      e0 = errors;                              // Write then read back
      send(make_req(1'b1, 32'h0000_0010, 32'hCAFE_F00D, 32'h1000_0001));
      send(make_req(1'b0, 32'h0000_0010, 32'h0, 32'h2000_0002));
      drain();
      report_test("write_read", e0);

      e0 = errors;                              // Index 63 never written yet
      send(make_req(1'b0, 32'h0000_00FC, 32'h0, 32'h3000_0003));
      drain();
      report_test("unwritten_read", e0);

      e0 = errors;
      for (int i = 0; i < 20; i++) begin
         addr[i] = rand_bits(32);
         data    = rand_bits(32);
         src     = rand_bits(32);
         send(make_req(1'b1, addr[i], data, src));
      end
      for (int i = 0; i < 20; i++) begin
         src = rand_bits(32);
         send(make_req(1'b0, addr[i], 32'h0, src));
      end
      drain();
      report_test("random_write_readback", e0);

      e0 = errors;                              // Access never dropped
      r0 = reads_sent;
      q0 = resp_count;
      both_wait_cycles = 0;
      for (int i = 0; i < 16; i++) begin
         is_wr = rand_bits(1);
         dst   = rand_bits(32);
         data  = rand_bits(32);
         src   = rand_bits(32);
         send(make_req(is_wr, dst, data, src));
      end
      drain();
      check_value(both_wait_cycles != 0, 1'b1, "both waits seen high");
      check_value(resp_count - q0, reads_sent - r0, "one response per read");
      report_test("back_to_back", e0);

      e0 = errors;                              // 16 words for frequent hits
      for (int i = 0; i < 30; i++) begin
         is_wr = rand_bits(1);
         dst   = rand_bits(32) & 32'hFFFF_FF3C;
         data  = rand_bits(32);
         src   = rand_bits(32);
         send(make_req(is_wr, dst, data, src));
      end
      drain();
      report_test("mixed_random", e0);

      $display("%0d tests, %0d failed, %0d checks, %0d errors, %0d responses",
               tests, failed_tests, checks, errors, resp_count);
      if (errors == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

//--- files.f
verilog/link_pkg.sv
verilog/link_tx.sv
verilog/link_rx.sv
verilog/link_mem.sv
verilog/link_loopback_top.sv
verification/link_loopback_tb.sv

//--- Bender.yml
package:
  name: link_loopback

dependencies: {}

sources:
  - files:
      - verilog/link_pkg.sv
      - verilog/link_tx.sv
      - verilog/link_rx.sv
      - verilog/link_mem.sv
      - verilog/link_loopback_top.sv
  - target: simulation
    files:
      - verification/link_loopback_tb.sv
